// File: common/cpu_pkg.sv
package cpu_pkg;

	// data path width
	localparam int XLEN = 32;
	// register count and index width
	localparam int NREGS = 16;
	localparam int REG_IDX_W = 4;
	// immediate field width, sign-extended to XLEN
	localparam int IMM_W = 16;

	// one data word
	typedef logic [XLEN-1:0] word_t;

	// register index
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// raw instruction word
	// op 31..28, ra 27..24, rb 23..20, rd 19..16, imm 15..0
	typedef logic [31:0] instr_t;

	// instruction opcodes, anything unlisted is illegal
	typedef enum logic [3:0] {
		OP_NOP  = 4'd0,
		OP_ADDI = 4'd1,
		OP_ADD  = 4'd2,
		OP_SUB  = 4'd3,
		OP_AND  = 4'd4,
		OP_OR   = 4'd5,
		OP_XOR  = 4'd6,
		OP_OUT  = 4'd15
	} opcode_e;

	// alu functions
	typedef enum logic [2:0] {
		ALU_ADD    = 3'd0,
		ALU_SUB    = 3'd1,
		ALU_AND    = 3'd2,
		ALU_OR     = 3'd3,
		ALU_XOR    = 3'd4,
		// operand a straight through, used by out
		ALU_PASS_A = 3'd5
	} alu_op_e;

endpackage

// File: logic/alu_execute.sv
`timescale 1ns/1ps

module alu_execute import cpu_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     stall,
	input  logic     dec_valid,
	input  alu_op_e  dec_alu_op,
	input  reg_idx_t dec_rd,
	input  reg_idx_t dec_ra,
	input  reg_idx_t dec_rb,
	input  word_t    dec_imm,
	input  logic     dec_use_imm,
	input  logic     dec_wr_en,
	input  logic     dec_out,
	input  word_t    rf_rdata_a,
	input  word_t    rf_rdata_b,
	output logic     ex_valid,
	output reg_idx_t ex_rd,
	output logic     ex_wr_en,
	output logic     ex_out,
	output word_t    ex_data
);

	// operand path
	logic  fwd_a;
	logic  fwd_b;
	logic  ex_writes;
	word_t op_a;
	word_t reg_b;
	word_t op_b;
	word_t alu_res;

	// execute reg still holds a result the regfile has not seen
	assign ex_writes = ex_valid && ex_wr_en;
	assign fwd_a = ex_writes && (ex_rd == dec_ra);
	assign fwd_b = ex_writes && (ex_rd == dec_rb);

	// forwarded value wins over regfile read
	assign op_a = fwd_a ? ex_data : rf_rdata_a;
	assign reg_b = fwd_b ? ex_data : rf_rdata_b;

	// addi takes the immediate in place of b
	assign op_b = dec_use_imm ? dec_imm : reg_b;

	// alu, 32-bit wrap on add and sub
	always_comb begin
		case (dec_alu_op)
			ALU_ADD: alu_res = op_a + op_b;
			ALU_SUB: alu_res = op_a - op_b;
			ALU_AND: alu_res = op_a & op_b;
			ALU_OR: alu_res = op_a | op_b;
			ALU_XOR: alu_res = op_a ^ op_b;
			ALU_PASS_A: alu_res = op_a;
			default: alu_res = op_a;
		endcase
	end

	// control flags of the execute reg
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid <= 1'b0;
			ex_wr_en <= 1'b0;
			ex_out <= 1'b0;
		end else if (!stall) begin
			ex_valid <= dec_valid;
			ex_wr_en <= dec_valid && dec_wr_en;
			ex_out <= dec_valid && dec_out;
		end
	end

	// result payload, frozen with the rest under stall
	always_ff @(posedge clk) begin
		if (!stall) begin
			ex_rd <= dec_rd;
			ex_data <= alu_res;
		end
	end

	// decode must hand over a defined function for every live slot
	a_op_known: assert property (@(posedge clk) disable iff (rst)
		dec_valid |-> !$isunknown(dec_alu_op));

endmodule

// File: logic/instr_decode.sv
`timescale 1ns/1ps

module instr_decode import cpu_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     instr_valid,
	input  instr_t   instr,
	output logic     instr_ready,
	input  logic     stall,
	output logic     dec_valid,
	output alu_op_e  dec_alu_op,
	output reg_idx_t dec_rd,
	output reg_idx_t dec_ra,
	output reg_idx_t dec_rb,
	output word_t    dec_imm,
	output logic     dec_use_imm,
	output logic     dec_wr_en,
	output logic     dec_out
);

	// decoded view of the incoming word
	opcode_e opcode;
	alu_op_e alu_op_n;
	logic    live_n;
	logic    wr_en_n;
	logic    out_n;
	logic    use_imm_n;
	logic    accept;

	// no room only while the output is blocked
	assign instr_ready = !stall;
	assign accept = instr_valid && instr_ready;
	assign opcode = opcode_e'(instr[31:28]);

	// opcode to alu function and flags
	always_comb begin
		alu_op_n = ALU_ADD;
		live_n = 1'b1;
		wr_en_n = 1'b1;
		out_n = 1'b0;
		use_imm_n = 1'b0;
		case (opcode)
			OP_ADDI: use_imm_n = 1'b1;
			OP_ADD: alu_op_n = ALU_ADD;
			OP_SUB: alu_op_n = ALU_SUB;
			OP_AND: alu_op_n = ALU_AND;
			OP_OR: alu_op_n = ALU_OR;
			OP_XOR: alu_op_n = ALU_XOR;
			OP_OUT: begin
				alu_op_n = ALU_PASS_A;
				wr_en_n = 1'b0;
				out_n = 1'b1;
			end
			// nop and illegal both become a bubble
			default: begin
				live_n = 1'b0;
				wr_en_n = 1'b0;
			end
		endcase
	end

	// control flags, bubble when nothing was taken
	always_ff @(posedge clk) begin
		if (rst) begin
			dec_valid <= 1'b0;
			dec_wr_en <= 1'b0;
			dec_out <= 1'b0;
		end else if (!stall) begin
			dec_valid <= accept && live_n;
			dec_wr_en <= accept && live_n && wr_en_n;
			dec_out <= accept && live_n && out_n;
		end
	end

	// field payload, only on a real transfer
	always_ff @(posedge clk) begin
		if (accept) begin
			dec_alu_op <= alu_op_n;
			dec_ra <= instr[27:24];
			dec_rb <= instr[23:20];
			dec_rd <= instr[19:16];
			// sign-extend imm
			dec_imm <= {{(XLEN-IMM_W){instr[IMM_W-1]}}, instr[IMM_W-1:0]};
			dec_use_imm <= use_imm_n;
		end
	end

	// a slot either writes a register or emits a word, never both
	a_wr_xor_out: assert property (@(posedge clk) disable iff (rst)
		!(dec_wr_en && dec_out));

endmodule

// File: logic/mini_cpu.sv
`timescale 1ns/1ps

module mini_cpu import cpu_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   instr_valid,
	input  instr_t instr,
	output logic   instr_ready,
	output logic   out_valid,
	output word_t  out_data,
	input  logic   out_ready
);

	// decode to execute
	logic     dec_valid;
	alu_op_e  dec_alu_op;
	reg_idx_t dec_rd;
	reg_idx_t dec_ra;
	reg_idx_t dec_rb;
	word_t    dec_imm;
	logic     dec_use_imm;
	logic     dec_wr_en;
	logic     dec_out;

	// regfile reads
	word_t    rf_rdata_a;
	word_t    rf_rdata_b;

	// execute to result
	logic     ex_valid;
	reg_idx_t ex_rd;
	logic     ex_wr_en;
	logic     ex_out;
	word_t    ex_data;

	// writeback and freeze
	logic     rf_we;
	reg_idx_t rf_waddr;
	word_t    rf_wdata;
	logic     stall;

	instr_decode u_decode (
		.clk, .rst, .instr_valid, .instr, .instr_ready, .stall,
		.dec_valid, .dec_alu_op, .dec_rd, .dec_ra, .dec_rb,
		.dec_imm, .dec_use_imm, .dec_wr_en, .dec_out
	);

	// read addresses straight from the decode reg
	reg_file u_regs (
		.clk, .rst,
		.raddr_a(dec_ra), .raddr_b(dec_rb),
		.rdata_a(rf_rdata_a), .rdata_b(rf_rdata_b),
		.we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
	);

	alu_execute u_exec (
		.clk, .rst, .stall,
		.dec_valid, .dec_alu_op, .dec_rd, .dec_ra, .dec_rb,
		.dec_imm, .dec_use_imm, .dec_wr_en, .dec_out,
		.rf_rdata_a, .rf_rdata_b,
		.ex_valid, .ex_rd, .ex_wr_en, .ex_out, .ex_data
	);

	result_stage u_result (
		.clk, .rst,
		.ex_valid, .ex_rd, .ex_wr_en, .ex_out, .ex_data,
		.rf_we, .rf_waddr, .rf_wdata,
		.out_valid, .out_data, .out_ready, .stall
	);

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  reg_idx_t raddr_a,
	input  reg_idx_t raddr_b,
	output word_t    rdata_a,
	output word_t    rdata_b,
	input  logic     we,
	input  reg_idx_t waddr,
	input  word_t    wdata
);

	// register array
	word_t regs [NREGS];

	// sync clear, then one write per clock
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// read ports are plain muxes
	// same-cycle write is not visible here, execute forwards it instead
	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];

endmodule

// File: logic/result_stage.sv
`timescale 1ns/1ps

module result_stage import cpu_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     ex_valid,
	input  reg_idx_t ex_rd,
	input  logic     ex_wr_en,
	input  logic     ex_out,
	input  word_t    ex_data,
	output logic     rf_we,
	output reg_idx_t rf_waddr,
	output word_t    rf_wdata,
	output logic     out_valid,
	output word_t    out_data,
	input  logic     out_ready,
	output logic     stall
);

	logic take_out;

	// output word waiting and nobody taking it
	assign stall = out_valid && !out_ready;

	// writeback waits while the pipe is frozen
	assign rf_we = ex_valid && ex_wr_en && !stall;
	assign rf_waddr = ex_rd;
	assign rf_wdata = ex_data;

	// an out instruction moves into the output reg
	assign take_out = ex_valid && ex_out && !stall;

	// no stall means the slot is empty or being drained this edge
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (!stall) begin
			out_valid <= take_out;
		end
	end

	// held until taken
	always_ff @(posedge clk) begin
		if (take_out) begin
			out_data <= ex_data;
		end
	end

	// word held steady until the consumer takes it
	a_out_hold: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

	// the pipe only freezes on a pending word
	a_stall_src: assert property (@(posedge clk) disable iff (rst)
		stall |-> out_valid);

endmodule

// File: mini_cpu.f
+incdir+verif
common/cpu_pkg.sv
logic/instr_decode.sv
logic/reg_file.sv
logic/alu_execute.sv
logic/result_stage.sv
logic/mini_cpu.sv
verif/tb_mini_cpu.sv

// File: verif/cpu_ref_model.svh
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

// architectural registers as the program sees them
word_t model_regs [NREGS];

// reset clears every register
function automatic void model_reset();
	for (int i = 0; i < NREGS; i++) begin
		model_regs[i] = '0;
	end
endfunction

// run one accepted instruction
// returns 1 when it sends a word out
// that word comes back in out_word
function automatic logic model_exec(input instr_t ins, output word_t out_word);
	logic [3:0] op;
	word_t      a;
	word_t      b;
	word_t      imm;
	reg_idx_t   rd;
	op = ins[31:28];
	a = model_regs[ins[27:24]];
	b = model_regs[ins[23:20]];
	rd = ins[19:16];
	// immediate taken as signed and widened to a full word
	imm = word_t'($signed(ins[15:0]));
	out_word = '0;
	case (op)
		OP_ADDI: model_regs[rd] = a + imm;
		OP_ADD: model_regs[rd] = a + b;
		OP_SUB: model_regs[rd] = a - b;
		OP_AND: model_regs[rd] = a & b;
		OP_OR: model_regs[rd] = a | b;
		OP_XOR: model_regs[rd] = a ^ b;
		OP_OUT: begin
			out_word = a;
			return 1'b1;
		end
		// nop and undefined opcodes leave state alone
		default: ;
	endcase
	return 1'b0;
endfunction

// three-register form
function automatic instr_t enc_alu(input logic [3:0] op, input reg_idx_t rd,
	input reg_idx_t ra, input reg_idx_t rb);
	return {op, ra, rb, rd, 16'h0000};
endfunction

function automatic instr_t enc_addi(input reg_idx_t rd, input reg_idx_t ra,
	input logic [15:0] imm);
	return {OP_ADDI, ra, 4'h0, rd, imm};
endfunction

function automatic instr_t enc_out(input reg_idx_t ra);
	return {OP_OUT, ra, 24'h000000};
endfunction

// any opcode with arbitrary field bits for nops and illegal words
function automatic instr_t enc_raw(input logic [3:0] op, input logic [27:0] fields);
	return {op, fields};
endfunction

`endif

// File: verif/tb_mini_cpu.sv
`timescale 1ns/1ps

module tb_mini_cpu import cpu_pkg::*; ();

	// cycles any single wait may take before the run is abandoned
	localparam int WAIT_LIMIT = 2000;

	logic   clk;
	logic   rst;
	logic   instr_valid;
	instr_t instr;
	logic   instr_ready;
	logic   out_valid;
	word_t  out_data;
	logic   out_ready;

	// stimulus state
	integer seed;
	logic   bp_mode;
	logic   ready_roll;
	// words the model says must come out in order
	word_t  exp_q [$];

	// bookkeeping
	int error_count;
	int check_count;
	int test_count;
	int failed_tests;
	int errors_at_start;

	`include "cpu_ref_model.svh"

	mini_cpu i_dut (
		.clk, .rst, .instr_valid, .instr, .instr_ready,
		.out_valid, .out_data, .out_ready
	);

	// 40 ns period
	always #20 clk = ~clk;

	// consumer stays ready unless back-pressure is on
	// next ready level rolled on the rising edge
	// and driven on the falling edge
	initial begin
		out_ready = 1'b1;
		forever begin
			@(posedge clk);
			ready_roll = ({$random(seed)} % 3 != 0);
			@(negedge clk);
			out_ready = bp_mode ? ready_roll : 1'b1;
		end
	end

	// one compare per output transfer
	always @(posedge clk) begin
		if (!rst && out_valid && out_ready) begin
			if (exp_q.size() == 0) begin
				$display("%0t ns: out word %h arrived but none was expected", $time, out_data);
				error_count++;
			end else begin
				check_word(out_data, exp_q.pop_front());
			end
		end
	end

	task automatic check_word(input word_t got, input word_t exp);
		check_count++;
		if (got !== exp) begin
			$display("[FAIL] %0t ns: out word %h, expected %h", $time, got, exp);
			error_count++;
		end
	endtask

	function automatic reg_idx_t rand_reg();
		return reg_idx_t'($random(seed));
	endfunction

	// one of add, sub, and, or, xor
	function automatic logic [3:0] rand_alu_op();
		return 4'(OP_ADD + {$random(seed)} % 5);
	endfunction

	// starts on a falling edge and returns on the one after the transfer
	task automatic send_instr(input instr_t ins);
		word_t ow;
		logic  emits;
		int    waited;
		instr = ins;
		instr_valid = 1'b1;
		waited = 0;
		@(posedge clk);
		while (!instr_ready && waited < WAIT_LIMIT) begin
			waited++;
			@(posedge clk);
		end
		if (!instr_ready) begin
			$display("timeout: instruction %h was not accepted within %0d cycles",
				ins, WAIT_LIMIT);
			$display("FAIL: see errors above");
			$finish;
		end else begin
			// model follows the DUT at the moment of acceptance
			emits = model_exec(ins, ow);
			if (emits) begin
				exp_q.push_back(ow);
			end
			@(negedge clk);
		end
	endtask

	// stop feeding and wait for every expected word
	task automatic wait_drain();
		int waited;
		instr_valid = 1'b0;
		waited = 0;
		while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
			waited++;
			@(posedge clk);
		end
		if (exp_q.size() != 0) begin
			$display("timeout: %0d out words still missing after %0d cycles",
				exp_q.size(), WAIT_LIMIT);
			$display("FAIL: see errors above");
			$finish;
		end else begin
			@(negedge clk);
		end
	endtask

	// switched away from the falling edge the consumer samples on
	task automatic set_backpressure(input logic on);
		@(posedge clk);
		bp_mode = on;
		@(negedge clk);
	endtask

	// random alu op followed by an out of its destination
	task automatic send_random_alu();
		reg_idx_t rd;
		rd = rand_reg();
		send_instr(enc_alu(rand_alu_op(), rd, rand_reg(), rand_reg()));
		send_instr(enc_out(rd));
	endtask

	task automatic dump_all_regs();
		for (int r = 0; r < NREGS; r++) begin
			send_instr(enc_out(reg_idx_t'(r)));
		end
	endtask

	task automatic start_test();
		errors_at_start = error_count;
	endtask

	task automatic finish_test(input string name);
		wait_drain();
		test_count++;
		if (error_count == errors_at_start) begin
			$display("test %s: ok", name);
		end else begin
			failed_tests++;
			$display("test %s: %0d errors", name, error_count - errors_at_start);
		end
	endtask

	initial begin
		reg_idx_t rd;
		reg_idx_t ra;
		seed = 32'h9ed3;
		clk = 1'b0;
		rst = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		bp_mode = 1'b0;
		error_count = 0;
		check_count = 0;
		test_count = 0;
		failed_tests = 0;
		model_reset();
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// every register reads zero out of reset
		start_test();
		dump_all_regs();
		finish_test("reset_state");

		// positive, negative and edge immediates
		start_test();
		send_instr(enc_addi(4'd1, 4'd0, 16'h1234));
		send_instr(enc_out(4'd1));
		send_instr(enc_addi(4'd2, 4'd1, 16'hfffb));
		send_instr(enc_out(4'd2));
		send_instr(enc_addi(4'd3, 4'd0, 16'h8000));
		send_instr(enc_out(4'd3));
		send_instr(enc_addi(4'd4, 4'd3, 16'h7fff));
		send_instr(enc_out(4'd4));
		repeat (12) begin
			rd = rand_reg();
			send_instr(enc_addi(rd, rand_reg(), 16'($random(seed))));
			send_instr(enc_out(rd));
		end
		finish_test("immediates");

		// r7 cleared first and then forced wraparound both ways
		start_test();
		send_instr(enc_alu(OP_XOR, 4'd7, 4'd0, 4'd0));
		send_instr(enc_addi(4'd8, 4'd7, 16'hffff));
		send_instr(enc_addi(4'd9, 4'd7, 16'h0001));
		send_instr(enc_alu(OP_ADD, 4'd10, 4'd8, 4'd9));
		send_instr(enc_out(4'd10));
		send_instr(enc_alu(OP_SUB, 4'd11, 4'd7, 4'd9));
		send_instr(enc_out(4'd11));
		send_instr(enc_alu(OP_ADD, 4'd12, 4'd11, 4'd11));
		send_instr(enc_out(4'd12));
		repeat (40) send_random_alu();
		finish_test("alu_functions");

		// each op reads what the one before just wrote
		start_test();
		send_instr(enc_addi(4'd1, 4'd1, 16'd3));
		send_instr(enc_alu(OP_ADD, 4'd2, 4'd1, 4'd1));
		send_instr(enc_alu(OP_SUB, 4'd3, 4'd2, 4'd1));
		send_instr(enc_alu(OP_XOR, 4'd1, 4'd3, 4'd2));
		send_instr(enc_alu(OP_AND, 4'd4, 4'd1, 4'd3));
		send_instr(enc_alu(OP_OR, 4'd5, 4'd4, 4'd1));
		send_instr(enc_out(4'd5));
		rd = 4'd5;
		repeat (20) begin
			ra = rd;
			rd = rand_reg();
			send_instr(enc_alu(rand_alu_op(), rd, ra, ({$random(seed)} % 2) ? ra : rand_reg()));
		end
		send_instr(enc_out(rd));
		dump_all_regs();
		finish_test("forwarding");

		// consumer stalls at random
		start_test();
		set_backpressure(1'b1);
		repeat (30) send_random_alu();
		dump_all_regs();
		finish_test("backpressure");
		set_backpressure(1'b0);

		// junk words mixed into a live stream
		start_test();
		repeat (40) begin
			case ({$random(seed)} % 3)
				0: send_instr(enc_raw(4'(7 + {$random(seed)} % 8), 28'($random(seed))));
				1: send_instr(enc_raw(OP_NOP, 28'($random(seed))));
				default: send_random_alu();
			endcase
		end
		dump_all_regs();
		finish_test("illegal_opcodes");

		// quiet window so a stray word would still be caught
		repeat (8) @(posedge clk);
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			test_count, failed_tests, check_count, error_count);
		if (error_count == 0 && failed_tests == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
